/* Makefile */
# Verilator build and run of the settings core testbench
# Override on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_u2_settings_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/core_types_pkg.sv */
`default_nettype none
/* Shared types of the settings core: bus widths, the internal write word
   and the time loader states. Imported by every RTL module that needs them */

package core_types_pkg;

   //////////////////////////////
   // Settings bus

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // One queued settings write, address in the top bits
   typedef struct packed {
      set_addr_t addr;
      set_data_t data;
   } set_write_t;

   //////////////////////////////
   // Time and readback

   // Counts dsp_clk ticks
   typedef logic [63:0] vita_time_t;

   typedef logic [3:0]  rb_addr_t;
   typedef logic [31:0] rb_data_t;

   typedef logic [7:0]  led_t;

   // Time loader, waiting or armed for the next PPS
   typedef enum logic {TL_IDLE, TL_ARMED} time_load_e;

endpackage

`default_nettype wire

/* logic/misc_regs.sv */
`default_nettype none
/* Control setting registers for the SERDES, ADC and PHY lines, and the LED
   mux that picks hardware status or software values bit by bit */

module misc_regs
   import core_types_pkg::*;
   import settings_map_pkg::*;
(
   input  wire             dsp_clk,
   input  wire             rst_i,
   input  wire set_write_t wr_i,
   input  wire             wr_stb_i,
   input  wire             run_rx_i,
   input  wire             run_tx_i,
   input  wire             clk_status_i,
   input  wire             link_up_i,
   input  wire             good_sync_i,
   output logic            ser_enable_o,
   output logic            ser_prbsen_o,
   output logic            ser_loopen_o,
   output logic            ser_rx_en_o,
   output logic            adc_oe_a_o,
   output logic            adc_on_a_o,
   output logic            adc_oe_b_o,
   output logic            adc_on_b_o,
   output logic            phy_resetn_o,
   output led_t            leds_o
);

   localparam set_addr_t ADDR_SERDES  = SR_MISC + 8'd1;
   localparam set_addr_t ADDR_ADC     = SR_MISC + 8'd2;
   localparam set_addr_t ADDR_LED_SW  = SR_MISC + 8'd3;
   localparam set_addr_t ADDR_PHY     = SR_MISC + 8'd4;
   localparam set_addr_t ADDR_LED_SRC = SR_MISC + 8'd6;

   logic [3:0] serdes_q;
   logic [3:0] adc_q;
   logic       phy_reset_q;
   led_t       led_sw_q;
   led_t       led_src_q;
   led_t       led_hw;

   //////////////////////////////
   // Register file

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         serdes_q    <= '0;
         adc_q       <= '0;
         phy_reset_q <= 1'b0;
         led_sw_q    <= '0;
         led_src_q   <= LED_SRC_RESET;
      end else if (wr_stb_i) begin
         case (wr_i.addr)
            ADDR_SERDES:  serdes_q    <= wr_i.data[3:0];
            ADDR_ADC:     adc_q       <= wr_i.data[3:0];
            ADDR_LED_SW:  led_sw_q    <= wr_i.data[7:0];
            ADDR_PHY:     phy_reset_q <= wr_i.data[0];
            ADDR_LED_SRC: led_src_q   <= wr_i.data[7:0];
            default:      ;
         endcase
      end
   end

   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_q;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}       = adc_q;

   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_reset_q;

   //////////////////////////////
   // LEDs

   // Sync LED only lights once the link is up and time is locked to PPS
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    link_up_i & good_sync_i, 1'b0};

   // Source bit 1 selects hardware, 0 selects software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

`default_nettype wire

/* logic/readback_mux.sv */
`default_nettype none
/* Registered readback selector for the 16 readback words. The word picked
   by rb_addr_i shows on rb_data_o one cycle later */

module readback_mux
   import core_types_pkg::*;
   import settings_map_pkg::*;
(
   input  wire             dsp_clk,
   input  wire             rst_i,
   input  wire rb_addr_t   rb_addr_i,
   input  wire vita_time_t time_i,
   input  wire vita_time_t time_pps_i,
   input  wire             clk_status_i,
   input  wire             link_up_i,
   output rb_data_t        rb_data_o
);

   rb_data_t irq_word;

   // Clock status at bit 11, link at bit 10
   assign irq_word = {20'd0, clk_status_i, link_up_i, 10'd0};

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         rb_data_o <= RB_UNUSED;
      end else begin
         case (rb_addr_i)
            RB_TIME_HI: rb_data_o <= time_i[63:32];
            RB_TIME_LO: rb_data_o <= time_i[31:0];
            RB_COMPAT:  rb_data_o <= COMPAT_NUM;
            RB_IRQ:     rb_data_o <= irq_word;
            RB_PPS_HI:  rb_data_o <= time_pps_i[63:32];
            RB_PPS_LO:  rb_data_o <= time_pps_i[31:0];
            default:    rb_data_o <= RB_UNUSED;
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/settings_intake.sv */
`default_nettype none
/* Credit-managed intake of settings writes. Queues incoming address/data
   pairs and releases one per cycle, returning a credit with each release */

module settings_intake
   import core_types_pkg::*;
#(
   parameter int CREDITS = 4
) (
   input  wire            dsp_clk,
   input  wire            rst_i,
   input  wire            set_valid_i,
   input  wire set_addr_t set_addr_i,
   input  wire set_data_t set_data_i,
   output logic           set_credit_o,
   output set_write_t     wr_o,
   output logic           wr_stb_o
);

   localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
   localparam int CNT_W = $clog2(CREDITS + 1);
   localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(CREDITS - 1);
   localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(CREDITS);

   set_write_t       queue_mem [CREDITS];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   // Circular pointer step, also for depths that are not a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
   endfunction

   assign push = set_valid_i;
   // Drain whenever something is queued, the sender is throttled by credits
   assign pop  = (count_q != '0);

   always_ff @(posedge dsp_clk) begin
      if (push) begin
         queue_mem[wr_ptr_q] <= '{addr: set_addr_i, data: set_data_i};
      end
   end

   // Head entry, valid while wr_stb_o is high
   always_ff @(posedge dsp_clk) begin
      if (pop) begin
         wr_o <= queue_mem[rd_ptr_q];
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         wr_stb_o <= 1'b0;
      end else begin
         wr_stb_o <= pop;
         if (push) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Credit goes back in the cycle the write is applied
   assign set_credit_o = wr_stb_o;

   // Sender spent a credit it did not hold
   a_no_push_full: assert property (@(posedge dsp_clk) disable iff (rst_i)
      !(push && count_q == FULL_CNT))
      else $error("settings write pushed into a full queue");

   a_count_bound: assert property (@(posedge dsp_clk) disable iff (rst_i)
      count_q <= FULL_CNT)
      else $error("settings queue count above its depth");

endmodule

`default_nettype wire

/* logic/settings_map_pkg.sv */
`default_nettype none
/* Register map of the settings core: setting addresses, readback word
   indices, the compat number and reset values of the setting registers */

package settings_map_pkg;
   import core_types_pkg::*;

   //////////////////////////////
   // Setting register bases

   // Control registers, serdes at +1, adc +2, sw leds +3, phy +4, led src +6
   localparam set_addr_t SR_MISC   = 8'd0;

   // Time staging hi +0, lo +1, control +2
   localparam set_addr_t SR_TIME64 = 8'd10;

   //////////////////////////////
   // Readback word indices

   localparam rb_addr_t RB_TIME_HI = 4'd10;
   localparam rb_addr_t RB_TIME_LO = 4'd11;
   localparam rb_addr_t RB_COMPAT  = 4'd12;
   localparam rb_addr_t RB_IRQ     = 4'd13;
   localparam rb_addr_t RB_PPS_HI  = 4'd14;
   localparam rb_addr_t RB_PPS_LO  = 4'd15;

   //////////////////////////////
   // Constants

   // Bump when the register map changes; major in the top half
   localparam rb_data_t COMPAT_NUM = {16'd10, 16'd1};

   // Returned for every index that has no word behind it
   localparam rb_data_t RB_UNUSED = 32'hFFFF_FFFF;

   // Status LEDs under hardware control out of reset
   localparam led_t LED_SRC_RESET = 8'b0001_1110;

endpackage

`default_nettype wire

/* logic/u2_settings_core.sv */
`default_nettype none
/* Top level of the DSP-side control plane: settings intake, control
   registers, VITA time and readback, all on dsp_clk */

module u2_settings_core
   import core_types_pkg::*;
#(
   parameter int CREDITS = 4
) (
   input  wire            dsp_clk,
   input  wire            rst_i,

   // Settings writes, credit flow control
   input  wire            set_valid_i,
   input  wire set_addr_t set_addr_i,
   input  wire set_data_t set_data_i,
   output logic           set_credit_o,

   // Readback
   input  wire rb_addr_t  rb_addr_i,
   output rb_data_t       rb_data_o,

   // Timing and status
   input  wire            pps_i,
   input  wire            run_rx_i,
   input  wire            run_tx_i,
   input  wire            clk_status_i,
   input  wire            link_up_i,

   // Control lines
   output led_t           leds_o,
   output logic           ser_enable_o,
   output logic           ser_prbsen_o,
   output logic           ser_loopen_o,
   output logic           ser_rx_en_o,
   output logic           adc_oe_a_o,
   output logic           adc_on_a_o,
   output logic           adc_oe_b_o,
   output logic           adc_on_b_o,
   output logic           phy_resetn_o
);

   set_write_t wr;
   logic       wr_stb;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       good_sync;

   //////////////////////////////
   // Settings path

   settings_intake #(
      .CREDITS(CREDITS)
   ) settings_intake_inst (
      .dsp_clk(dsp_clk), .rst_i(rst_i),
      .set_valid_i(set_valid_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .set_credit_o(set_credit_o), .wr_o(wr), .wr_stb_o(wr_stb)
   );

   misc_regs misc_regs_inst (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .wr_i(wr), .wr_stb_i(wr_stb),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i), .clk_status_i(clk_status_i),
      .link_up_i(link_up_i), .good_sync_i(good_sync),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o)
   );

   //////////////////////////////
   // Time and readback

   vita_time_counter vita_time_counter_inst (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .wr_i(wr), .wr_stb_i(wr_stb), .pps_i(pps_i),
      .time_o(vita_time), .time_pps_o(vita_time_pps), .good_sync_o(good_sync)
   );

   readback_mux readback_mux_inst (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .rb_addr_i(rb_addr_i),
      .time_i(vita_time), .time_pps_i(vita_time_pps),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .rb_data_o(rb_data_o)
   );

endmodule

`default_nettype wire

/* logic/vita_time_counter.sv */
`default_nettype none
/* 64-bit VITA time counter on dsp_clk. Loaded at once or at the next PPS
   edge from two staging words, and latched on every PPS edge */

module vita_time_counter
   import core_types_pkg::*;
   import settings_map_pkg::*;
(
   input  wire             dsp_clk,
   input  wire             rst_i,
   input  wire set_write_t wr_i,
   input  wire             wr_stb_i,
   input  wire             pps_i,
   output vita_time_t      time_o,
   output vita_time_t      time_pps_o,
   output logic            good_sync_o
);

   localparam set_addr_t ADDR_TIME_HI   = SR_TIME64;
   localparam set_addr_t ADDR_TIME_LO   = SR_TIME64 + 8'd1;
   localparam set_addr_t ADDR_TIME_CTRL = SR_TIME64 + 8'd2;

   set_data_t  stage_hi_q;
   set_data_t  stage_lo_q;
   vita_time_t staged_time;
   logic       ctrl_wr;
   logic       load_now;
   logic       arm_load;
   logic       pps_meta_q;
   logic       pps_sync_q;
   logic       pps_prev_q;
   logic       pps_edge;
   time_load_e state_q;

   //////////////////////////////
   // Staging and control decode

   always_ff @(posedge dsp_clk) begin
      if (wr_stb_i && wr_i.addr == ADDR_TIME_HI) begin
         stage_hi_q <= wr_i.data;
      end
      if (wr_stb_i && wr_i.addr == ADDR_TIME_LO) begin
         stage_lo_q <= wr_i.data;
      end
   end

   assign staged_time = {stage_hi_q, stage_lo_q};
   assign ctrl_wr     = wr_stb_i && (wr_i.addr == ADDR_TIME_CTRL);
   assign load_now    = ctrl_wr && wr_i.data[0];
   assign arm_load    = ctrl_wr && wr_i.data[1];

   //////////////////////////////
   // PPS synchronizer

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         pps_meta_q <= 1'b0;
         pps_sync_q <= 1'b0;
         pps_prev_q <= 1'b0;
      end else begin
         pps_meta_q <= pps_i;
         pps_sync_q <= pps_meta_q;
         pps_prev_q <= pps_sync_q;
      end
   end

   assign pps_edge = pps_sync_q & ~pps_prev_q;

   //////////////////////////////
   // Counter, latch and loader

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         time_o      <= '0;
         time_pps_o  <= '0;
         good_sync_o <= 1'b0;
         state_q     <= TL_IDLE;
      end else begin
         time_o <= time_o + 64'd1;
         if (load_now) begin
            time_o      <= staged_time;
            good_sync_o <= 1'b0;
         end
         if (pps_edge) begin
            if (state_q == TL_ARMED) begin
               // Latch shows the time the edge was given
               time_o      <= staged_time;
               time_pps_o  <= staged_time;
               good_sync_o <= 1'b1;
               state_q     <= TL_IDLE;
            end else begin
               time_pps_o <= time_o;
            end
         end
         // A fresh arm outranks the edge that ends the previous one
         if (arm_load) begin
            state_q <= TL_ARMED;
         end
      end
   end

   // While armed only the PPS edge or an explicit load may move the time
   a_armed_load_on_pps: assert property (@(posedge dsp_clk) disable iff (rst_i)
      (state_q == TL_ARMED && !pps_edge && !load_now)
         |=> (time_o == $past(time_o) + 64'd1))
      else $error("time loaded while armed without a PPS edge");

endmodule

`default_nettype wire

/* src.f */
logic/core_types_pkg.sv
logic/settings_map_pkg.sv
logic/settings_intake.sv
logic/misc_regs.sv
logic/vita_time_counter.sv
logic/readback_mux.sv
logic/u2_settings_core.sv
verification/tb_u2_settings_core.sv
+incdir+include

/* include/tb_checks.svh */
/* Compare tasks and the xorshift generator for the settings core testbench.
   Include inside the testbench module after importing core_types_pkg */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// First mismatch ends the run
task automatic report_mismatch(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
   $display("Mismatch in %s: got %0h, expected %0h", what, got, exp);
   $display("Something failed");
   $fatal(1, "check failed");
endtask

task automatic check_rb(input string what, input rb_data_t got, input rb_data_t exp);
   if (got !== exp) begin
      report_mismatch(what, 64'(got), 64'(exp));
   end
endtask

task automatic check_led(input string what, input led_t got, input led_t exp);
   if (got !== exp) begin
      report_mismatch(what, 64'(got), 64'(exp));
   end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
   if (got !== exp) begin
      report_mismatch(what, 64'(got), 64'(exp));
   end
endtask

// Serdes nibble, adc nibble, then phy_resetn in bit 0
task automatic check_ctrl(input string what, input logic [8:0] got, input logic [8:0] exp);
   if (got !== exp) begin
      report_mismatch(what, 64'(got), 64'(exp));
   end
endtask

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] state);
   logic [31:0] s;
   s = state;
   s = s ^ (s << 13);
   s = s ^ (s >> 17);
   s = s ^ (s << 5);
   return s;
endfunction

`endif

/* verification/tb_u2_settings_core.sv */
`default_nettype none
/* Directed testbench for u2_settings_core. Sends settings writes under credit
   flow control and checks control lines, LEDs, VITA time and readback */

module tb_u2_settings_core
   import core_types_pkg::*;
   import settings_map_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   `include "tb_checks.svh"

   localparam int CREDITS    = 4;
   localparam int NUM_TESTS  = 6;
   localparam int CLK_PERIOD = 40;

   logic       dsp_clk;
   logic       rst_i;
   logic       set_valid_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   logic       set_credit_o;
   rb_addr_t   rb_addr_i;
   rb_data_t   rb_data_o;
   logic       pps_i;
   logic       run_rx_i;
   logic       run_tx_i;
   logic       clk_status_i;
   logic       link_up_i;
   led_t       leds_o;
   logic       ser_enable_o;
   logic       ser_prbsen_o;
   logic       ser_loopen_o;
   logic       ser_rx_en_o;
   logic       adc_oe_a_o;
   logic       adc_on_a_o;
   logic       adc_oe_b_o;
   logic       adc_on_b_o;
   logic       phy_resetn_o;
   wire  [8:0] ctrl_lines = {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o,
                             adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_resetn_o};

   // Driver credit bookkeeping and model state
   int          spent = 0;
   int          returned = 0;
   int          cycles = 0;
   logic [31:0] rng_state = 32'd10;
   logic [8:0]  exp_ctrl = 9'b0000_0000_1;
   led_t        led_src = 8'b0001_1110;
   led_t        led_sw = '0;
   logic        exp_sync = 1'b0;

   u2_settings_core #(
      .CREDITS(CREDITS)
   ) u2_settings_core_inst (
      .dsp_clk(dsp_clk), .rst_i(rst_i),
      .set_valid_i(set_valid_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .set_credit_o(set_credit_o), .rb_addr_i(rb_addr_i), .rb_data_o(rb_data_o),
      .pps_i(pps_i), .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i), .leds_o(leds_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o), .phy_resetn_o(phy_resetn_o)
   );

   initial dsp_clk = 1'b0;
   always #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) cycles <= cycles + 1;

   // Credit pulses are stable mid-cycle
   always @(negedge dsp_clk) begin
      if (set_credit_o === 1'b1) begin
         returned++;
      end
   end

   initial begin
      repeat (NUM_TESTS * 2000) @(posedge dsp_clk);
      $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 2000);
      $display("Something failed");
      $fatal(1, "watchdog expired");
   end

   //////////////////////////////
   // Helpers

   function automatic set_data_t next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Mux rule with the hardware bit wherever the source bit is 1
   function automatic led_t expected_leds();
      led_t hw;
      hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, link_up_i & exp_sync, 1'b0};
      return (led_src & hw) | (~led_src & led_sw);
   endfunction

   // Leaves set_valid_i high so that writes can go back to back
   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(posedge dsp_clk);
      while (CREDITS - spent + returned <= 0) begin
         set_valid_i <= 1'b0;
         @(posedge dsp_clk);
      end
      set_valid_i <= 1'b1;
      set_addr_i  <= addr;
      set_data_i  <= data;
      spent++;
   endtask

   task automatic end_writes();
      @(posedge dsp_clk);
      set_valid_i <= 1'b0;
   endtask

   // Last credit marks the write being applied on the next edge
   task automatic wait_drained();
      while (returned != spent) begin
         @(negedge dsp_clk);
      end
      @(negedge dsp_clk);
   endtask

   task automatic read_word(input rb_addr_t addr, output rb_data_t data);
      @(posedge dsp_clk);
      rb_addr_i <= addr;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      data = rb_data_o;
   endtask

   // High half first as software reads it
   task automatic read_time(output vita_time_t t);
      rb_data_t hi;
      rb_data_t lo;
      read_word(RB_TIME_HI, hi);
      read_word(RB_TIME_LO, lo);
      t = {hi, lo};
   endtask

   // Synchronized edge acts 3 cycles after the rise
   task automatic pulse_pps();
      @(posedge dsp_clk);
      pps_i <= 1'b1;
      repeat (8) @(posedge dsp_clk);
      pps_i <= 1'b0;
      @(negedge dsp_clk);
   endtask

   //////////////////////////////
   // Tests

   task automatic test_reset_state();
      rb_data_t data;
      @(negedge dsp_clk);
      check_ctrl("reset control lines", ctrl_lines, exp_ctrl);
      check_led("reset leds", leds_o, expected_leds());
      read_word(RB_COMPAT, data);
      check_rb("reset compat", data, 32'h000A_0001);
      read_word(4'd3, data);
      check_rb("reset unused index", data, 32'hFFFF_FFFF);
   endtask

   task automatic test_control_regs();
      set_data_t ser;
      set_data_t adc;
      set_data_t phy;
      ser = next_random();
      adc = next_random();
      phy = next_random();
      write_setting(SR_MISC + 8'd1, ser);
      write_setting(SR_MISC + 8'd2, adc);
      write_setting(SR_MISC + 8'd4, phy);
      end_writes();
      wait_drained();
      exp_ctrl = {ser[3:0], adc[3:0], ~phy[0]};
      check_ctrl("control registers", ctrl_lines, exp_ctrl);
   endtask

   task automatic test_led_mux();
      set_data_t status;
      rb_data_t  data;
      rb_data_t  exp_irq;
      for (int i = 0; i < 4; i++) begin
         led_sw  = led_t'(next_random());
         led_src = led_t'(next_random());
         status  = next_random();
         write_setting(SR_MISC + 8'd3, 32'(led_sw));
         write_setting(SR_MISC + 8'd6, 32'(led_src));
         end_writes();
         wait_drained();
         @(posedge dsp_clk);
         {run_rx_i, run_tx_i, clk_status_i, link_up_i} <= status[3:0];
         @(negedge dsp_clk);
         check_led("led mux", leds_o, expected_leds());
         // Status word carries clock status at bit 11 and link at bit 10
         read_word(RB_IRQ, data);
         exp_irq     = '0;
         exp_irq[11] = clk_status_i;
         exp_irq[10] = link_up_i;
         check_rb("led mux status word", data, exp_irq);
      end
   endtask

   task automatic test_credit_flow();
      int        start;
      int        pulses;
      set_data_t last;
      start = returned;
      for (int i = 0; i < CREDITS; i++) begin
         last = next_random();
         write_setting(SR_MISC + 8'd2, last);
      end
      end_writes();
      wait_drained();
      repeat (10) @(negedge dsp_clk);
      pulses = returned - start;
      if (pulses != CREDITS) begin
         report_mismatch("credit flow pulses", 64'(pulses), 64'(CREDITS));
      end
      exp_ctrl[4:1] = last[3:0];
      check_ctrl("credit flow last write", ctrl_lines, exp_ctrl);
   endtask

   task automatic test_pps_load();
      vita_time_t v;
      vita_time_t t;
      rb_data_t   hi;
      rb_data_t   lo;
      // Clear top bits so no half wraps during the reads
      v = {next_random() & 32'h7FFF_FFFF, next_random() & 32'h7FFF_FFFF};
      led_src = 8'hFF;
      led_sw  = 8'h00;
      write_setting(SR_MISC + 8'd6, 32'(led_src));
      write_setting(SR_TIME64, v[63:32]);
      write_setting(SR_TIME64 + 8'd1, v[31:0]);
      write_setting(SR_TIME64 + 8'd2, 32'd2);
      end_writes();
      wait_drained();
      @(posedge dsp_clk);
      link_up_i <= 1'b1;
      @(negedge dsp_clk);
      check_bit("pps load sync led before edge", leds_o[1], 1'b0);
      pulse_pps();
      exp_sync = 1'b1;
      check_bit("pps load sync led", leds_o[1], 1'b1);
      read_word(RB_PPS_HI, hi);
      read_word(RB_PPS_LO, lo);
      check_rb("pps load latch high", hi, v[63:32]);
      check_rb("pps load latch low", lo, v[31:0]);
      read_time(t);
      if (t < v) begin
         report_mismatch("pps load time", t, v);
      end
   endtask

   task automatic test_load_now();
      vita_time_t w;
      vita_time_t t;
      int         start;
      int         elapsed;
      w = {next_random() & 32'h7FFF_FFFF, next_random() & 32'h7FFF_FFFF};
      write_setting(SR_TIME64, w[63:32]);
      write_setting(SR_TIME64 + 8'd1, w[31:0]);
      write_setting(SR_TIME64 + 8'd2, 32'd1);
      start = cycles;
      end_writes();
      wait_drained();
      read_time(t);
      elapsed = cycles - start;
      if (t < w) begin
         report_mismatch("load now time low bound", t, w);
      end
      if (t > w + 64'(elapsed)) begin
         report_mismatch("load now time high bound", t, w + 64'(elapsed));
      end
      exp_sync = 1'b0;
      check_bit("load now clears sync led", leds_o[1], 1'b0);
   endtask

   //////////////////////////////
   // Main sequence

   initial begin
      rst_i        <= 1'b1;
      set_valid_i  <= 1'b0;
      set_addr_i   <= '0;
      set_data_i   <= '0;
      rb_addr_i    <= '0;
      pps_i        <= 1'b0;
      run_rx_i     <= 1'b1;
      run_tx_i     <= 1'b0;
      clk_status_i <= 1'b1;
      link_up_i    <= 1'b1;
      repeat (4) @(posedge dsp_clk);
      rst_i <= 1'b0;
      test_reset_state();
      test_control_regs();
      test_led_mux();
      test_credit_flow();
      test_pps_load();
      test_load_now();
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire
